//--- src.f
logic/nic_pkg.sv
logic/nic_csr.sv
logic/nic_rpc_bridge.sv
logic/nic_rate_meter.sv
logic/nic_pck_counters.sv
logic/nic_top.sv
verif/nic_tb.sv

//--- Makefile
# Verilator build and run of the NIC testbench

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/100ps -j 0 -f src.f --top-module nic_tb

run: build
	@out="$$(./obj_dir/Vnic_tb)"; echo "$$out"; echo "$$out" | grep -qx "test passed"

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f src.f --top-module nic_top

clean:
	rm -rf obj_dir

//--- verif/nic_tb.sv
// NIC testbench
// Directed tests of the MMIO CSRs, the RPC to network bridge, the
// packet counters and the request rate meter

`timescale 1ns/100ps
`default_nettype none

module nic_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int RSP_TIMEOUT  = 10;
    localparam int RPS_POLLS    = 200;

    logic               ccip_clk;
    logic               reset;
    nic_pkg::mmio_req_t mmio_req;
    nic_pkg::mmio_rsp_t mmio_rsp;
    nic_pkg::rpc_t      rpc_in;
    logic               rpc_in_valid;
    nic_pkg::rpc_t      rpc_out;
    logic               rpc_out_valid;
    nic_pkg::net_pkt_t  net_tx;
    logic               net_tx_valid;
    nic_pkg::net_pkt_t  net_rx;
    logic               net_rx_valid;

    int                             errors;
    int                             tests_ok;
    int                             tests_bad;
    int                             tx_seen;
    logic [nic_pkg::MMIO_TID_W-1:0] next_tid;
    // Expected counter values, indexed by counter id
    logic [63:0]                    exp_cnt [4];

    nic_top dut_i (
        .ccip_clk      (ccip_clk),
        .reset         (reset),
        .mmio_req      (mmio_req),
        .mmio_rsp      (mmio_rsp),
        .rpc_in        (rpc_in),
        .rpc_in_valid  (rpc_in_valid),
        .rpc_out       (rpc_out),
        .rpc_out_valid (rpc_out_valid),
        .net_tx        (net_tx),
        .net_tx_valid  (net_tx_valid),
        .net_rx        (net_rx),
        .net_rx_valid  (net_rx_valid)
    );

    always #(CLK_PERIOD / 2) ccip_clk = ~ccip_clk;

    // Transmitted packets seen on the network side
    always @(negedge ccip_clk) begin
        if (!reset && net_tx_valid) begin
            tx_seen = tx_seen + 1;
        end
    end

    // ==================================================
    // Reporting and bus tasks
    // ==================================================
    task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
        $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic fault(input string what);
        $display("Error at %0t ns: %s", $time, what);
        errors++;
    endtask

    task automatic finish_test(input string name, input int start_err);
        if (errors == start_err) begin
            $display("%s: ok", name);
            tests_ok++;
        end else begin
            $display("%s: FAILED with %0d errors", name, errors - start_err);
            tests_bad++;
        end
    endtask

    task automatic apply_reset();
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge ccip_clk);
        reset <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            exp_cnt[i] = '0;
        end
    endtask

    task automatic mmio_write(input logic [15:0] addr, input logic [63:0] data);
        @(posedge ccip_clk);
        mmio_req.wr_valid <= 1'b1;
        mmio_req.address  <= addr;
        mmio_req.data     <= data;
        @(posedge ccip_clk);
        mmio_req.wr_valid <= 1'b0;
    endtask

    task automatic mmio_read(input logic [15:0] addr, output logic [63:0] data);
        logic [nic_pkg::MMIO_TID_W-1:0] tid;
        int                             waited;
        tid      = next_tid;
        next_tid = next_tid + 1'b1;
        waited   = 0;
        data     = '0;
        @(posedge ccip_clk);
        mmio_req.rd_valid <= 1'b1;
        mmio_req.address  <= addr;
        mmio_req.tid      <= tid;
        @(posedge ccip_clk);
        mmio_req.rd_valid <= 1'b0;
        @(negedge ccip_clk);
        while (!mmio_rsp.valid && waited < RSP_TIMEOUT) begin
            @(negedge ccip_clk);
            waited++;
        end
        if (!mmio_rsp.valid) begin
            fault($sformatf("no MMIO response to the read of address %h", addr));
        end else begin
            if (waited != 0) begin
                fault($sformatf("MMIO response %0d cycles late", waited));
            end
            if (mmio_rsp.tid !== tid) begin
                mismatch("mmio_rsp.tid", 64'(mmio_rsp.tid), 64'(tid));
            end
            data = mmio_rsp.data;
        end
    endtask

    task automatic send_rpc(input nic_pkg::rpc_t req);
        @(posedge ccip_clk);
        rpc_in       <= req;
        rpc_in_valid <= 1'b1;
        @(posedge ccip_clk);
        rpc_in_valid <= 1'b0;
    endtask

    // Leaves the strobe up so packets can follow back to back
    task automatic send_net(input nic_pkg::net_pkt_t pkt);
        @(posedge ccip_clk);
        net_rx       <= pkt;
        net_rx_valid <= 1'b1;
    endtask

    task automatic end_net();
        @(posedge ccip_clk);
        net_rx_valid <= 1'b0;
    endtask

    // ==================================================
    // Tests
    // ==================================================
    task automatic test_identity();
        int          start_err;
        logic [63:0] rd;
        start_err = errors;
        mmio_read(nic_pkg::ADDR_DFH, rd);
        if (rd !== 64'h1000_0100_0000_0000) begin
            mismatch("dfh", rd, 64'h1000_0100_0000_0000);
        end
        mmio_read(nic_pkg::ADDR_AFU_ID_L, rd);
        if (rd !== nic_pkg::AFU_ID[63:0]) begin
            mismatch("afu_id_l", rd, nic_pkg::AFU_ID[63:0]);
        end
        mmio_read(nic_pkg::ADDR_AFU_ID_H, rd);
        if (rd !== nic_pkg::AFU_ID[127:64]) begin
            mismatch("afu_id_h", rd, nic_pkg::AFU_ID[127:64]);
        end
        mmio_read(16'h0030, rd);
        if (rd !== 64'd0) begin
            mismatch("unmapped", rd, 64'd0);
        end
        mmio_read(nic_pkg::ADDR_NIC_STATUS, rd);
        if (rd !== {59'd0, nic_pkg::NIC_ID, 1'b0}) begin
            mismatch("nic_status", rd, {59'd0, nic_pkg::NIC_ID, 1'b0});
        end
        finish_test("identity", start_err);
    endtask

    task automatic test_start_flows();
        int            start_err;
        int            tx_before;
        logic [63:0]   rd;
        nic_pkg::rpc_t req;
        start_err = errors;
        mmio_write(nic_pkg::ADDR_NUM_OF_FLOWS, 64'd4);
        mmio_write(nic_pkg::ADDR_NIC_START, 64'd1);
        mmio_read(nic_pkg::ADDR_NIC_STATUS, rd);
        if (rd !== {59'd0, nic_pkg::NIC_ID, 1'b1}) begin
            mismatch("nic_status", rd, {59'd0, nic_pkg::NIC_ID, 1'b1});
        end
        req.flow_id = 3'd2;
        req.rpc_id  = 16'($urandom);
        req.payload = {$urandom, $urandom};
        send_rpc(req);
        @(negedge ccip_clk);
        if (net_tx_valid !== 1'b1) begin
            fault("request on flow 2 gave no net_tx_valid one cycle later");
        end else begin
            if (net_tx.nic_id !== nic_pkg::NIC_ID) begin
                mismatch("net_tx.nic_id", 64'(net_tx.nic_id), 64'(nic_pkg::NIC_ID));
            end
            if (net_tx.flow_id !== req.flow_id) begin
                mismatch("net_tx.flow_id", 64'(net_tx.flow_id), 64'(req.flow_id));
            end
            if (net_tx.rpc_id !== req.rpc_id) begin
                mismatch("net_tx.rpc_id", 64'(net_tx.rpc_id), 64'(req.rpc_id));
            end
            if (net_tx.payload !== req.payload) begin
                mismatch("net_tx.payload", net_tx.payload, req.payload);
            end
        end
        exp_cnt[0] = exp_cnt[0] + 1;
        exp_cnt[2] = exp_cnt[2] + 1;
        // Flow 5 lies beyond the four configured flows
        @(posedge ccip_clk);
        tx_before   = tx_seen;
        req.flow_id = 3'd5;
        req.rpc_id  = 16'($urandom);
        send_rpc(req);
        repeat (5) @(posedge ccip_clk);
        if (tx_seen != tx_before) begin
            fault("request on out-of-range flow 5 was transmitted");
        end
        finish_test("start_and_flows", start_err);
    endtask

    task automatic test_stopped();
        int            start_err;
        int            tx_before;
        nic_pkg::rpc_t req;
        start_err = errors;
        mmio_write(nic_pkg::ADDR_NIC_START, 64'd0);
        @(posedge ccip_clk);
        tx_before = tx_seen;
        for (int i = 0; i < 4; i++) begin
            req.flow_id = 3'(i);
            req.rpc_id  = 16'($urandom);
            req.payload = {$urandom, $urandom};
            send_rpc(req);
        end
        repeat (20) @(posedge ccip_clk);
        if (tx_seen != tx_before) begin
            fault("stopped NIC transmitted a request");
        end
        finish_test("stopped_nic", start_err);
    endtask

    task automatic test_response();
        int                start_err;
        nic_pkg::net_pkt_t pkts [5];
        start_err = errors;
        for (int i = 0; i < 5; i++) begin
            pkts[i].nic_id  = 4'd5;
            pkts[i].flow_id = 3'(i);
            pkts[i].rpc_id  = 16'($urandom);
            pkts[i].payload = {$urandom, $urandom};
        end
        for (int i = 0; i <= 5; i++) begin
            if (i < 5) begin
                send_net(pkts[i]);
            end else begin
                end_net();
            end
            @(negedge ccip_clk);
            if (i == 0) begin
                if (rpc_out_valid !== 1'b0) begin
                    fault("rpc_out_valid rose in the same cycle as net_rx_valid");
                end
            end else if (rpc_out_valid !== 1'b1) begin
                fault($sformatf("no rpc_out for received packet %0d", i - 1));
            end else begin
                if (rpc_out.flow_id !== pkts[i-1].flow_id) begin
                    mismatch("rpc_out.flow_id", 64'(rpc_out.flow_id), 64'(pkts[i-1].flow_id));
                end
                if (rpc_out.rpc_id !== pkts[i-1].rpc_id) begin
                    mismatch("rpc_out.rpc_id", 64'(rpc_out.rpc_id), 64'(pkts[i-1].rpc_id));
                end
                if (rpc_out.payload !== pkts[i-1].payload) begin
                    mismatch("rpc_out.payload", rpc_out.payload, pkts[i-1].payload);
                end
            end
        end
        exp_cnt[1] = exp_cnt[1] + 5;
        exp_cnt[3] = exp_cnt[3] + 5;
        finish_test("response_path", start_err);
    endtask

    task automatic test_counters();
        int          start_err;
        logic [63:0] rd;
        start_err = errors;
        for (int id = 0; id < 4; id++) begin
            mmio_write(nic_pkg::ADDR_GET_PCK_CNT, 64'(id));
            mmio_read(nic_pkg::ADDR_PCK_CNT, rd);
            if (rd !== exp_cnt[id]) begin
                mismatch($sformatf("pck_cnt[%0d]", id), rd, exp_cnt[id]);
            end
        end
        mmio_write(nic_pkg::ADDR_GET_PCK_CNT, 64'd9);
        mmio_read(nic_pkg::ADDR_PCK_CNT, rd);
        if (rd !== 64'd0) begin
            mismatch("pck_cnt[9]", rd, 64'd0);
        end
        finish_test("counters", start_err);
    endtask

    task automatic test_rate();
        int            start_err;
        int            polls;
        logic [63:0]   rd;
        nic_pkg::rpc_t req;
        start_err = errors;
        @(posedge ccip_clk);
        apply_reset();
        mmio_write(nic_pkg::ADDR_NUM_OF_FLOWS, 64'd4);
        mmio_write(nic_pkg::ADDR_NIC_START, 64'd1);
        for (int i = 0; i < 6; i++) begin
            req.flow_id = 3'(i % 4);
            req.rpc_id  = 16'($urandom);
            req.payload = {$urandom, $urandom};
            send_rpc(req);
        end
        polls = 0;
        rd    = '0;
        while (rd === 64'd0 && polls < RPS_POLLS) begin
            mmio_read(nic_pkg::ADDR_RPS, rd);
            polls++;
        end
        if (rd === 64'd0) begin
            fault("RPS stayed zero after the first rate window");
        end else if (rd !== 64'd6) begin
            mismatch("rps", rd, 64'd6);
        end
        finish_test("rate", start_err);
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        ccip_clk     = 1'b0;
        reset        = 1'b1;
        mmio_req     = '0;
        rpc_in       = '0;
        rpc_in_valid = 1'b0;
        net_rx       = '0;
        net_rx_valid = 1'b0;
        errors       = 0;
        tests_ok     = 0;
        tests_bad    = 0;
        tx_seen      = 0;
        next_tid     = '0;
        void'($urandom(32'h5934));
        apply_reset();
        test_identity();
        test_start_flows();
        test_stopped();
        test_response();
        test_counters();
        test_rate();
        $display("Summary: %0d ok, %0d with errors, %0d errors in all",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Last line of defense against a stuck run
    initial begin
        #(CLK_PERIOD * 20000);
        $display("Simulation ran past its time limit");
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/nic_top.sv
// NIC top level
// Host MMIO control block, RPC/network bridge, request rate meter and
// packet counters, all on ccip_clk

`timescale 1ns/100ps
`default_nettype none

module nic_top (
    input  logic                   ccip_clk,
    input  logic                   reset,
    input  nic_pkg::mmio_req_t     mmio_req,
    output nic_pkg::mmio_rsp_t     mmio_rsp,
    input  nic_pkg::rpc_t          rpc_in,
    input  logic                   rpc_in_valid,
    output nic_pkg::rpc_t          rpc_out,
    output logic                   rpc_out_valid,
    output nic_pkg::net_pkt_t      net_tx,
    output logic                   net_tx_valid,
    input  nic_pkg::net_pkt_t      net_rx,
    input  logic                   net_rx_valid
);

    logic                          running;
    logic [nic_pkg::FLOW_ID_W-1:0] num_flows_m1;
    logic [nic_pkg::RATE_W-1:0]    rps;
    logic [7:0]                    cnt_sel;
    logic [nic_pkg::CNT_W-1:0]     cnt_value;
    logic                          rpc_accepted;
    logic                          rpc_responded;

    // ==================================================
    // Host control
    // ==================================================
    nic_csr csr_i (
        .ccip_clk     (ccip_clk),
        .reset        (reset),
        .mmio_req     (mmio_req),
        .mmio_rsp     (mmio_rsp),
        .running      (running),
        .num_flows_m1 (num_flows_m1),
        .rps          (rps),
        .cnt_sel      (cnt_sel),
        .cnt_value    (cnt_value)
    );

    // ==================================================
    // Datapath
    // ==================================================
    nic_rpc_bridge bridge_i (
        .ccip_clk      (ccip_clk),
        .reset         (reset),
        .running       (running),
        .num_flows_m1  (num_flows_m1),
        .rpc_in        (rpc_in),
        .rpc_in_valid  (rpc_in_valid),
        .net_tx        (net_tx),
        .net_tx_valid  (net_tx_valid),
        .net_rx        (net_rx),
        .net_rx_valid  (net_rx_valid),
        .rpc_out       (rpc_out),
        .rpc_out_valid (rpc_out_valid),
        .rpc_accepted  (rpc_accepted),
        .rpc_responded (rpc_responded)
    );

    // ==================================================
    // Statistics
    // ==================================================
    nic_rate_meter rate_i (
        .ccip_clk     (ccip_clk),
        .reset        (reset),
        .rpc_accepted (rpc_accepted),
        .rps          (rps)
    );

    nic_pck_counters cnt_i (
        .ccip_clk      (ccip_clk),
        .reset         (reset),
        .rpc_accepted  (rpc_accepted),
        .rpc_responded (rpc_responded),
        .net_tx_valid  (net_tx_valid),
        .net_rx_valid  (net_rx_valid),
        .cnt_sel       (cnt_sel),
        .cnt_value     (cnt_value)
    );

endmodule

`default_nettype wire

//--- logic/nic_pck_counters.sv
// Packet event counters
// One free-running counter per datapath event, with one of them
// picked by id for the CSR read path

`timescale 1ns/100ps
`default_nettype none

module nic_pck_counters (
    input  logic                      ccip_clk,
    input  logic                      reset,
    input  logic                      rpc_accepted,
    input  logic                      rpc_responded,
    input  logic                      net_tx_valid,
    input  logic                      net_rx_valid,
    input  logic [7:0]                cnt_sel,
    output logic [nic_pkg::CNT_W-1:0] cnt_value
);

    logic [nic_pkg::NUM_CNT-1:0] ev;
    logic [nic_pkg::CNT_W-1:0]   cnt [nic_pkg::NUM_CNT];

    // Event slot matches the counter id
    always_comb begin
        ev[nic_pkg::CNT_RPC_IN[1:0]]  = rpc_accepted;
        ev[nic_pkg::CNT_RPC_OUT[1:0]] = rpc_responded;
        ev[nic_pkg::CNT_NET_TX[1:0]]  = net_tx_valid;
        ev[nic_pkg::CNT_NET_RX[1:0]]  = net_rx_valid;
    end

    always_ff @(posedge ccip_clk) begin
        for (int i = 0; i < nic_pkg::NUM_CNT; i++) begin
            if (reset) begin
                cnt[i] <= '0;
            end else if (ev[i]) begin
                cnt[i] <= cnt[i] + 1;
            end
        end
    end

    // Unknown ids read as zero
    always_comb begin
        case (cnt_sel)
            nic_pkg::CNT_RPC_IN:  cnt_value = cnt[0];
            nic_pkg::CNT_RPC_OUT: cnt_value = cnt[1];
            nic_pkg::CNT_NET_TX:  cnt_value = cnt[2];
            nic_pkg::CNT_NET_RX:  cnt_value = cnt[3];
            default:              cnt_value = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/nic_rate_meter.sv
// Request rate meter
// Counts accepted requests over a fixed window of cycles and holds the
// total of the last completed window

`timescale 1ns/100ps
`default_nettype none

module nic_rate_meter (
    input  logic                       ccip_clk,
    input  logic                       reset,
    input  logic                       rpc_accepted,
    output logic [nic_pkg::RATE_W-1:0] rps
);

    logic [$clog2(nic_pkg::RATE_WINDOW)-1:0] win_cnt;
    logic [nic_pkg::RATE_W-1:0]              ev_cnt;
    logic [nic_pkg::RATE_W-1:0]              ev_next;
    logic                                    win_end;

    // Count including this cycle's pulse
    assign ev_next = rpc_accepted ? ev_cnt + 1 : ev_cnt;
    assign win_end = (32'(win_cnt) == nic_pkg::RATE_WINDOW - 1);

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            win_cnt <= '0;
            ev_cnt  <= '0;
            rps     <= '0;
        end else if (win_end) begin
            win_cnt <= '0;
            ev_cnt  <= '0;
            rps     <= ev_next;
        end else begin
            win_cnt <= win_cnt + 1'b1;
            ev_cnt  <= ev_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/nic_rpc_bridge.sv
// RPC to network bridge
// Filters host requests by run state and flow range and turns them
// into network packets; turns received packets into RPC responses

`timescale 1ns/100ps
`default_nettype none

module nic_rpc_bridge (
    input  logic                          ccip_clk,
    input  logic                          reset,
    input  logic                          running,
    input  logic [nic_pkg::FLOW_ID_W-1:0] num_flows_m1,
    input  nic_pkg::rpc_t                 rpc_in,
    input  logic                          rpc_in_valid,
    output nic_pkg::net_pkt_t             net_tx,
    output logic                          net_tx_valid,
    input  nic_pkg::net_pkt_t             net_rx,
    input  logic                          net_rx_valid,
    output nic_pkg::rpc_t                 rpc_out,
    output logic                          rpc_out_valid,
    output logic                          rpc_accepted,
    output logic                          rpc_responded
);

    logic accept;

    // Stopped NIC or unknown flow drops the request
    assign accept = rpc_in_valid && running && (rpc_in.flow_id <= num_flows_m1);

    // ==================================================
    // Request side
    // ==================================================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            net_tx_valid <= 1'b0;
        end else begin
            net_tx_valid <= accept;
        end
    end

    always_ff @(posedge ccip_clk) begin
        if (accept) begin
            net_tx.nic_id  <= nic_pkg::NIC_ID;
            net_tx.flow_id <= rpc_in.flow_id;
            net_tx.rpc_id  <= rpc_in.rpc_id;
            net_tx.payload <= rpc_in.payload;
        end
    end

    // ==================================================
    // Response side
    // ==================================================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            rpc_out_valid <= 1'b0;
        end else begin
            rpc_out_valid <= net_rx_valid;
        end
    end

    // Sender nic_id is not carried back to the host
    always_ff @(posedge ccip_clk) begin
        if (net_rx_valid) begin
            rpc_out.flow_id <= net_rx.flow_id;
            rpc_out.rpc_id  <= net_rx.rpc_id;
            rpc_out.payload <= net_rx.payload;
        end
    end

    assign rpc_accepted  = net_tx_valid;
    assign rpc_responded = rpc_out_valid;

endmodule

`default_nettype wire

//--- logic/nic_csr.sv
// NIC control and status registers
// Decodes host MMIO writes into the configuration registers and
// answers every MMIO read one cycle later with the addressed word

`timescale 1ns/100ps
`default_nettype none

module nic_csr (
    input  logic                              ccip_clk,
    input  logic                              reset,
    input  nic_pkg::mmio_req_t                mmio_req,
    output nic_pkg::mmio_rsp_t                mmio_rsp,
    output logic                              running,
    output logic [nic_pkg::FLOW_ID_W-1:0]     num_flows_m1,
    input  logic [nic_pkg::RATE_W-1:0]        rps,
    output logic [7:0]                        cnt_sel,
    input  logic [nic_pkg::CNT_W-1:0]         cnt_value
);

    nic_pkg::nic_status_t                status;
    logic [nic_pkg::MMIO_DATA_W-1:0]     rd_data;
    logic                                rsp_valid;
    logic [nic_pkg::MMIO_TID_W-1:0]      rsp_tid;
    logic [nic_pkg::MMIO_DATA_W-1:0]     rsp_data;

    // ==================================================
    // Write decode
    // ==================================================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            running      <= 1'b0;
            num_flows_m1 <= '0;
            cnt_sel      <= 8'd0;
        end else if (mmio_req.wr_valid) begin
            case (mmio_req.address)
                nic_pkg::ADDR_NIC_START: begin
                    running <= mmio_req.data[0];
                end
                // Host writes the flow count, datapath wants the top flow id
                nic_pkg::ADDR_NUM_OF_FLOWS: begin
                    num_flows_m1 <= mmio_req.data[nic_pkg::FLOW_ID_W-1:0] - 1'b1;
                end
                nic_pkg::ADDR_GET_PCK_CNT: begin
                    cnt_sel <= mmio_req.data[7:0];
                end
                default: begin
                end
            endcase
        end
    end

    // ==================================================
    // Read mux
    // ==================================================
    always_comb begin
        status.nic_id  = nic_pkg::NIC_ID;
        status.running = running;
    end

    always_comb begin
        rd_data = '0;
        case (mmio_req.address)
            // Single AFU feature, last in the list
            nic_pkg::ADDR_DFH: begin
                rd_data[63:60] = 4'h1;
                rd_data[40]    = 1'b1;
            end
            nic_pkg::ADDR_AFU_ID_L: begin
                rd_data = nic_pkg::AFU_ID[63:0];
            end
            nic_pkg::ADDR_AFU_ID_H: begin
                rd_data = nic_pkg::AFU_ID[127:64];
            end
            nic_pkg::ADDR_NIC_STATUS: begin
                rd_data[$bits(nic_pkg::nic_status_t)-1:0] = status;
            end
            nic_pkg::ADDR_RPS: begin
                rd_data[nic_pkg::RATE_W-1:0] = rps;
            end
            nic_pkg::ADDR_PCK_CNT: begin
                rd_data[nic_pkg::CNT_W-1:0] = cnt_value;
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

    // Response strobe, one per read
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= mmio_req.rd_valid;
        end
    end

    // Tag and data follow the strobe
    always_ff @(posedge ccip_clk) begin
        if (mmio_req.rd_valid) begin
            rsp_tid  <= mmio_req.tid;
            rsp_data <= rd_data;
        end
    end

    always_comb begin
        mmio_rsp.valid = rsp_valid;
        mmio_rsp.tid   = rsp_tid;
        mmio_rsp.data  = rsp_data;
    end

endmodule

`default_nettype wire

//--- logic/nic_pkg.sv
// NIC shared definitions
// Holds the constants, the CSR address map and the struct types used
// by the host control path and the RPC datapath

`default_nettype none

package nic_pkg;

    // ==================================================
    // NIC constants
    // ==================================================
    localparam int NIC_ID_W          = 4;
    localparam logic [NIC_ID_W-1:0] NIC_ID = 4'd3;
    localparam int LMAX_NUM_OF_FLOWS = 3;
    localparam int FLOW_ID_W         = LMAX_NUM_OF_FLOWS;
    localparam int RPC_ID_W          = 16;
    localparam int PAYLOAD_W         = 64;

    localparam int MMIO_ADDR_W = 16;
    localparam int MMIO_DATA_W = 64;
    localparam int MMIO_TID_W  = 9;

    // Accelerator UUID, low half read at AFU_ID_L
    localparam logic [127:0] AFU_ID = 128'h3c1e_7a42_9d05_4b68_a1f3_6e2c_8b94_d057;

    // Rate measurement and packet counters
    localparam int RATE_WINDOW = 256;
    localparam int RATE_W      = 32;
    localparam int CNT_W       = 64;
    localparam int NUM_CNT     = 4;

    localparam logic [7:0] CNT_RPC_IN  = 8'd0;
    localparam logic [7:0] CNT_RPC_OUT = 8'd1;
    localparam logic [7:0] CNT_NET_TX  = 8'd2;
    localparam logic [7:0] CNT_NET_RX  = 8'd3;

    // ==================================================
    // CSR address map
    // ==================================================
    // 64-bit registers at even 32-bit word addresses
    localparam logic [MMIO_ADDR_W-1:0] SRF_BASE          = 16'h10;
    localparam logic [MMIO_ADDR_W-1:0] ADDR_DFH          = 16'd0;
    localparam logic [MMIO_ADDR_W-1:0] ADDR_AFU_ID_L     = 16'd2;
    localparam logic [MMIO_ADDR_W-1:0] ADDR_AFU_ID_H     = 16'd4;
    localparam logic [MMIO_ADDR_W-1:0] ADDR_NIC_START    = SRF_BASE + 16'd4;
    localparam logic [MMIO_ADDR_W-1:0] ADDR_NUM_OF_FLOWS = SRF_BASE + 16'd6;
    localparam logic [MMIO_ADDR_W-1:0] ADDR_NIC_STATUS   = SRF_BASE + 16'd10;
    localparam logic [MMIO_ADDR_W-1:0] ADDR_RPS          = SRF_BASE + 16'd12;
    localparam logic [MMIO_ADDR_W-1:0] ADDR_GET_PCK_CNT  = SRF_BASE + 16'd14;
    localparam logic [MMIO_ADDR_W-1:0] ADDR_PCK_CNT      = SRF_BASE + 16'd16;

    // ==================================================
    // Struct types
    // ==================================================
    typedef struct packed {
        logic                   rd_valid;
        logic                   wr_valid;
        logic [MMIO_ADDR_W-1:0] address;
        logic [MMIO_TID_W-1:0]  tid;
        logic [MMIO_DATA_W-1:0] data;
    } mmio_req_t;

    typedef struct packed {
        logic                   valid;
        logic [MMIO_TID_W-1:0]  tid;
        logic [MMIO_DATA_W-1:0] data;
    } mmio_rsp_t;

    typedef struct packed {
        logic [FLOW_ID_W-1:0] flow_id;
        logic [RPC_ID_W-1:0]  rpc_id;
        logic [PAYLOAD_W-1:0] payload;
    } rpc_t;

    typedef struct packed {
        logic [NIC_ID_W-1:0]  nic_id;
        logic [FLOW_ID_W-1:0] flow_id;
        logic [RPC_ID_W-1:0]  rpc_id;
        logic [PAYLOAD_W-1:0] payload;
    } net_pkt_t;

    typedef struct packed {
        logic [NIC_ID_W-1:0] nic_id;
        logic                running;
    } nic_status_t;

endpackage

`default_nettype wire
